// File: dv/lsu_mem_checks.svh
// *************************************************************************
// LSU load path testbench checks
// Memory line model, expected writeback data and typed compare tasks
// *************************************************************************

`ifndef LSU_MEM_CHECKS_SVH
`define LSU_MEM_CHECKS_SVH

// Line content, fixed function of the whole line address
function automatic lsu_mem_pkg::line_data_t line_model(input lsu_mem_pkg::line_addr_t la);
    logic [31:0] a;
    a = 32'(la);
    return {a * 32'h9e37_79b9, a ^ 32'h5ac3_e10f ^ {a[15:0], a[31:16]}};
endfunction

// Result of a load at addr, byte i taken from byte i+k of the pair of lines
function automatic lsu_instr_pkg::wb_data_t expect_data(input logic [`LSU_ADDR_W-1:0] addr);
    lsu_mem_pkg::line_addr_t la;
    lsu_mem_pkg::line_data_t lo;
    lsu_mem_pkg::line_data_t hi;
    lsu_instr_pkg::wb_data_t res;
    int                      k;
    la = lsu_mem_pkg::line_addr_t'(addr / `LSU_LINE_BYTES);
    k  = addr % `LSU_LINE_BYTES;                 // Byte offset in the line
    lo = line_model(la);
    hi = line_model(la + 1'b1);                  // Only read when k is not zero
    for (int i = 0; i < `LSU_LINE_BYTES; i++) begin
        if (i + k < `LSU_LINE_BYTES) begin
            res[i*8 +: 8] = lo[(i + k)*8 +: 8];
        end else begin
            res[i*8 +: 8] = hi[(i + k - `LSU_LINE_BYTES)*8 +: 8];  // Wraps to next line
        end
    end
    return res;
endfunction

task automatic check_dest(input logic [`LSU_DEST_W-1:0] got, input logic [`LSU_DEST_W-1:0] exp);
    if (got !== exp) begin
        abort_run($sformatf("mismatch at %0t: wb_dest_o got %0d expected %0d",
                            $time, got, exp));
    end
endtask

task automatic check_data(input lsu_instr_pkg::wb_data_t got,
                          input lsu_instr_pkg::wb_data_t exp);
    if (got !== exp) begin
        abort_run($sformatf("mismatch at %0t: wb_data_o got %h expected %h",
                            $time, got, exp));
    end
endtask

task automatic check_tag(input lsu_mem_pkg::mem_tag_t got, input lsu_mem_pkg::mem_tag_t exp);
    if (got !== exp) begin
        abort_run($sformatf("mismatch at %0t: req_tag_o got %0d expected %0d",
                            $time, got, exp));
    end
endtask

task automatic check_addr(input lsu_mem_pkg::line_addr_t got,
                          input lsu_mem_pkg::line_addr_t exp);
    if (got !== exp) begin
        abort_run($sformatf("mismatch at %0t: req_addr_o got %h expected %h",
                            $time, got, exp));
    end
endtask

`endif

// File: dv/lsu_mem_tb.sv
// *************************************************************************
// LSU load path testbench
// Clock, reset, DUT, out of order memory responder, writeback monitor
// and the directed tests
// *************************************************************************

`include "lsu_config.svh"

module lsu_mem_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NEAR_FULL = `LSU_PMRQ_ENTRIES - 2;  // busy_o threshold

    logic                       clk_i;
    logic                       rstn_i;
    logic                       flush_i;
    logic                       instr_valid_i;
    lsu_instr_pkg::load_instr_t instr_i;
    logic                       busy_o;
    logic                       req_valid_o;
    lsu_mem_pkg::line_addr_t    req_addr_o;
    lsu_mem_pkg::mem_tag_t      req_tag_o;
    logic                       rsp_valid_i;
    lsu_mem_pkg::mem_tag_t      rsp_tag_i;
    lsu_mem_pkg::line_data_t    rsp_data_i;
    logic                       wb_valid_o;
    logic [`LSU_DEST_W-1:0]     wb_dest_o;
    lsu_instr_pkg::wb_data_t    wb_data_o;

    lsu_mem_pkg::line_addr_t    mem_addr_q[$];      // Requests not yet answered
    lsu_mem_pkg::mem_tag_t      mem_tag_q[$];
    bit                         mem_hold;           // Memory silent
    bit                         mem_reverse;        // Newest request answered first
    logic [`LSU_DEST_W-1:0]     exp_dest[$];        // Expected writebacks, in order
    lsu_instr_pkg::wb_data_t    exp_data[$];
    lsu_mem_pkg::mem_tag_t      next_tag;           // Tag of the next request

    lsu_mem_top DUT (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    `include "lsu_mem_checks.svh"

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic wait_ready();
        int n;
        n = 0;
        while (busy_o !== 1'b0) begin
            @(negedge clk_i);
            n++;
            if (n > 200)
                abort_run("timeout waiting for busy_o to fall");
        end
    endtask

    task automatic wait_retired();
        int n;
        n = 0;
        while (exp_dest.size() != 0) begin
            @(negedge clk_i);
            n++;
            if (n > 2000)
                abort_run("timeout waiting for accepted loads to retire");
        end
    endtask

    task automatic wait_mem_quiet();
        int n;
        n = 0;
        while (mem_tag_q.size() != 0) begin
            @(negedge clk_i);
            n++;
            if (n > 500)
                abort_run("timeout waiting for memory to answer every request");
        end
    endtask

    // Offer one load, then check its one or two line requests
    task automatic issue_load(input logic [`LSU_ADDR_W-1:0] addr,
                              input logic [`LSU_DEST_W-1:0] dest);
        lsu_mem_pkg::line_addr_t la;
        la = lsu_mem_pkg::line_addr_t'(addr / `LSU_LINE_BYTES);
        wait_ready();
        instr_valid_i = 1'b1;
        instr_i.addr  = addr;
        instr_i.dest  = dest;
        exp_dest.push_back(dest);
        exp_data.push_back(expect_data(addr));
        @(negedge clk_i);
        instr_valid_i = 1'b0;
        if (req_valid_o !== 1'b1)
            abort_run("no line request after an accepted load");
        check_tag(req_tag_o, next_tag);
        check_addr(req_addr_o, la);
        next_tag++;
        if (addr % `LSU_LINE_BYTES != 0) begin      // Spans into the next line
            @(negedge clk_i);
            if (req_valid_o !== 1'b1)
                abort_run("no second line request for an unaligned load");
            if (busy_o !== 1'b1)
                abort_run("busy_o low while the second line request goes out");
            check_tag(req_tag_o, next_tag);
            check_addr(req_addr_o, la + 1'b1);
            next_tag++;
        end
    endtask

    // Records requests, answers one per cycle at most
    task automatic serve_memory();
        int idx;
        forever begin
            @(negedge clk_i);
            rsp_valid_i = 1'b0;
            if (req_valid_o === 1'b1) begin
                mem_addr_q.push_back(req_addr_o);
                mem_tag_q.push_back(req_tag_o);
            end
            if (!mem_hold && mem_tag_q.size() != 0 && $urandom_range(2, 0) == 0) begin
                idx = mem_reverse ? mem_tag_q.size() - 1
                                  : $urandom_range(mem_tag_q.size() - 1, 0);
                rsp_valid_i = 1'b1;
                rsp_tag_i   = mem_tag_q[idx];
                rsp_data_i  = line_model(mem_addr_q[idx]);
                mem_tag_q.delete(idx);
                mem_addr_q.delete(idx);
            end
        end
    endtask

    task automatic watch_writebacks();
        forever begin
            @(negedge clk_i);
            if (wb_valid_o === 1'b1) begin
                if (exp_dest.size() == 0)
                    abort_run("writeback with no load outstanding");
                check_dest(wb_dest_o, exp_dest.pop_front());
                check_data(wb_data_o, exp_data.pop_front());
            end
        end
    endtask

    task automatic test_aligned();
        issue_load(32'h0000_1040, 5'd3);
        wait_retired();
    endtask

    task automatic test_unaligned();
        issue_load(32'h0000_2f3d, 5'd17);           // Offset 5
        wait_retired();
    endtask

    task automatic test_reverse_order();
        mem_hold    = 1'b1;
        mem_reverse = 1'b1;
        for (int i = 0; i < 6; i++) begin
            issue_load(32'h0001_0000 + i * 8 + (i % 2) * 3, `LSU_DEST_W'(i + 1));
        end
        mem_hold = 1'b0;
        wait_retired();
        mem_reverse = 1'b0;
    endtask

    task automatic test_back_pressure();
        mem_hold = 1'b1;
        for (int n = 1; n <= NEAR_FULL; n++) begin
            issue_load(32'h0002_0000 + n * 8, `LSU_DEST_W'(n));
            if (n < NEAR_FULL && busy_o !== 1'b0)
                abort_run("busy_o rose before the queue was near full");
        end
        if (busy_o !== 1'b1)
            abort_run("busy_o still low with the queue near full");
        mem_hold = 1'b0;
        wait_retired();
    endtask

    task automatic test_flush();
        mem_hold = 1'b1;
        issue_load(32'h0003_0010, 5'd7);
        issue_load(32'h0003_0026, 5'd8);
        @(negedge clk_i);
        flush_i = 1'b1;
        exp_dest.delete();                          // Flushed loads never retire
        exp_data.delete();
        @(negedge clk_i);
        flush_i  = 1'b0;
        mem_hold = 1'b0;
        wait_mem_quiet();                           // Late responses for dead tags
        repeat (4) @(negedge clk_i);
        issue_load(32'h0003_0041, 5'd9);
        wait_retired();
    endtask

    task automatic test_random_mix();
        for (int i = 0; i < 40; i++) begin
            issue_load($urandom & 32'h00ff_ffff, `LSU_DEST_W'($urandom_range(31, 0)));
        end
        wait_retired();
    endtask

    initial begin
        void'($urandom(32'h3019e701));
        rstn_i        = 1'b0;
        flush_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rsp_valid_i   = 1'b0;
        rsp_tag_i     = '0;
        rsp_data_i    = '0;
        mem_hold      = 1'b0;
        mem_reverse   = 1'b0;
        next_tag      = '0;
        repeat (4) @(negedge clk_i);
        if (busy_o !== 1'b1)
            abort_run("busy_o low during reset");
        rstn_i = 1'b1;
        fork
            serve_memory();
            watch_writebacks();
        join_none
        test_aligned();
        test_unaligned();
        test_reverse_order();
        test_back_pressure();
        test_flush();
        test_random_mix();
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: rtl/lsu_config.svh
// *************************************************************************
// LSU load path configuration
// Sizes shared by the packages and the RTL of the memory unit
// *************************************************************************

`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// Pending memory request queue depth
`define LSU_PMRQ_ENTRIES 8

// Request tag width, wide enough that flushed tags do not alias live ones
`define LSU_TAG_W 6

// Bytes per memory line, a whole line is read per request
`define LSU_LINE_BYTES 8

// Byte address width
`define LSU_ADDR_W 32

// Register file index width
`define LSU_DEST_W 5

`endif

// File: rtl/lsu_instr_pkg.sv
// *************************************************************************
// LSU instruction types
// Load instruction as seen by issue, queue and writeback, plus the
// result and byte offset types used when a load retires
// *************************************************************************

`include "lsu_config.svh"

package lsu_instr_pkg;

    // Offset bits inside one memory line
    localparam int OFF_W = $clog2(`LSU_LINE_BYTES);

    // One load, full byte address plus destination register
    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] addr;  // Byte address, may be unaligned
        logic [`LSU_DEST_W-1:0] dest;  // Register to write on retire
    } load_instr_t;

    // Retired data, one line wide
    typedef logic [`LSU_LINE_BYTES*8-1:0] wb_data_t;

    // Byte position within a line
    typedef logic [OFF_W-1:0] byte_off_t;

endpackage

// File: rtl/lsu_mem_pkg.sv
// *************************************************************************
// LSU memory side types
// Line requests, line data and request tags exchanged with memory
// *************************************************************************

`include "lsu_config.svh"

package lsu_mem_pkg;

    // Address bits left once the line offset is dropped
    localparam int LINE_ADDR_W = `LSU_ADDR_W - $clog2(`LSU_LINE_BYTES);

    // Tag that pairs a response with its request
    typedef logic [`LSU_TAG_W-1:0] mem_tag_t;

    // Line-aligned address, offset bits removed
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

    // One memory line, 64 bits with the default line size
    typedef logic [`LSU_LINE_BYTES*8-1:0] line_data_t;

endpackage

// File: rtl/lsu_mem_top.sv
// *************************************************************************
// LSU load path top
// Issue, pending request queue and writeback in a three stage pipeline
// *************************************************************************

`include "lsu_config.svh"

module lsu_mem_top (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       flush_i,
    input  logic                       instr_valid_i,
    input  lsu_instr_pkg::load_instr_t instr_i,
    output logic                       busy_o,
    output logic                       req_valid_o,
    output lsu_mem_pkg::line_addr_t    req_addr_o,
    output lsu_mem_pkg::mem_tag_t      req_tag_o,
    input  logic                       rsp_valid_i,
    input  lsu_mem_pkg::mem_tag_t      rsp_tag_i,
    input  lsu_mem_pkg::line_data_t    rsp_data_i,
    output logic                       wb_valid_o,
    output logic [`LSU_DEST_W-1:0]     wb_dest_o,
    output lsu_instr_pkg::wb_data_t    wb_data_o
);

    // Issue to queue
    logic                       alloc_valid;
    lsu_instr_pkg::load_instr_t alloc_instr;
    lsu_mem_pkg::mem_tag_t      alloc_tag;
    logic                       alloc_unaligned;
    logic                       q_full;

    // Queue to writeback
    logic                       head_ready;
    lsu_instr_pkg::load_instr_t head_instr;
    lsu_mem_pkg::line_data_t    head_line_lo;
    lsu_mem_pkg::line_data_t    head_line_hi;
    logic                       pop;

    mem_req_issue u_issue (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .flush_i           (flush_i),
        .instr_valid_i     (instr_valid_i),
        .instr_i           (instr_i),
        .q_full_i          (q_full),
        .busy_o            (busy_o),
        .req_valid_o       (req_valid_o),
        .req_addr_o        (req_addr_o),
        .req_tag_o         (req_tag_o),
        .alloc_valid_o     (alloc_valid),
        .alloc_instr_o     (alloc_instr),
        .alloc_tag_o       (alloc_tag),
        .alloc_unaligned_o (alloc_unaligned)
    );

    pending_mem_req_queue u_pmrq (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .flush_i           (flush_i),
        .alloc_valid_i     (alloc_valid),
        .alloc_instr_i     (alloc_instr),
        .alloc_tag_i       (alloc_tag),
        .alloc_unaligned_i (alloc_unaligned),
        .rsp_valid_i       (rsp_valid_i),
        .rsp_tag_i         (rsp_tag_i),
        .rsp_data_i        (rsp_data_i),
        .pop_i             (pop),
        .head_ready_o      (head_ready),
        .head_instr_o      (head_instr),
        .head_line_lo_o    (head_line_lo),
        .head_line_hi_o    (head_line_hi),
        .full_o            (q_full)
    );

    mem_writeback_stage u_wb (
        .clk_i             (clk_i),
        .rstn_i            (rstn_i),
        .flush_i           (flush_i),
        .head_ready_i      (head_ready),
        .head_instr_i      (head_instr),
        .head_line_lo_i    (head_line_lo),
        .head_line_hi_i    (head_line_hi),
        .pop_o             (pop),
        .wb_valid_o        (wb_valid_o),
        .wb_dest_o         (wb_dest_o),
        .wb_data_o         (wb_data_o)
    );

endmodule

// File: rtl/mem_req_issue.sv
// *************************************************************************
// Memory request issue stage
// Tags each accepted load, sends one line request, or two with
// consecutive tags when the access spans a line boundary, and hands
// the load to the pending request queue
// *************************************************************************

module mem_req_issue (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic                      flush_i,
    input  logic                      instr_valid_i,      // Load offered this cycle
    input  lsu_instr_pkg::load_instr_t instr_i,
    input  logic                      q_full_i,           // Queue near full
    output logic                      busy_o,             // Do not offer a load
    output logic                      req_valid_o,
    output lsu_mem_pkg::line_addr_t   req_addr_o,
    output lsu_mem_pkg::mem_tag_t     req_tag_o,
    output logic                      alloc_valid_o,      // Write queue tail
    output lsu_instr_pkg::load_instr_t alloc_instr_o,
    output lsu_mem_pkg::mem_tag_t     alloc_tag_o,        // First tag of the load
    output logic                      alloc_unaligned_o
);

    lsu_instr_pkg::byte_off_t instr_off;
    lsu_mem_pkg::line_addr_t  instr_line;
    logic                     unaligned;
    logic                     accept;

    logic                     started_q;    // Low through reset, then high
    logic                     pend_q;       // Second line still to send
    logic                     req_hi_q;     // Upper line request on the bus
    lsu_mem_pkg::line_addr_t  pend_addr_q;
    lsu_mem_pkg::mem_tag_t    tag_q;        // Next free tag
    logic                     req_valid_q;
    lsu_mem_pkg::line_addr_t  req_addr_q;
    lsu_mem_pkg::mem_tag_t    req_tag_q;

    assign instr_off  = lsu_instr_pkg::byte_off_t'(instr_i.addr);  // Low address bits
    assign instr_line = lsu_mem_pkg::line_addr_t'(instr_i.addr >> lsu_instr_pkg::OFF_W);

    // Whole line is read, so any offset needs the next line too
    assign unaligned = (instr_off != '0);

    // Blocked through both line requests of an unaligned load, near full or flushing
    assign busy_o = ~started_q | pend_q | req_hi_q | q_full_i | flush_i;
    assign accept = instr_valid_i & ~busy_o;

    // Queue allocates on the edge that launches the first request
    assign alloc_valid_o     = accept;
    assign alloc_instr_o     = instr_i;
    assign alloc_tag_o       = tag_q;
    assign alloc_unaligned_o = unaligned;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            started_q   <= 1'b0;
            pend_q      <= 1'b0;
            req_hi_q    <= 1'b0;
            req_valid_q <= 1'b0;
            tag_q       <= '0;
        end else begin
            started_q <= 1'b1;
            req_hi_q  <= pend_q & ~flush_i;        // Second request launches
            if (flush_i) begin
                pend_q      <= 1'b0;               // Drop any second request
                req_valid_q <= 1'b0;
            end else if (pend_q) begin
                pend_q      <= 1'b0;               // Upper line with tag T+1
                req_valid_q <= 1'b1;
                tag_q       <= tag_q + 1'b1;
            end else if (accept) begin
                pend_q      <= unaligned;
                req_valid_q <= 1'b1;
                tag_q       <= tag_q + 1'b1;
            end else begin
                req_valid_q <= 1'b0;
            end
        end
    end

    // Request payload
    always_ff @(posedge clk_i) begin
        if (pend_q) begin
            req_addr_q <= pend_addr_q;
            req_tag_q  <= tag_q;
        end else if (accept) begin
            req_addr_q  <= instr_line;
            req_tag_q   <= tag_q;
            pend_addr_q <= instr_line + 1'b1;      // Following line
        end
    end

    assign req_valid_o = req_valid_q;
    assign req_addr_o  = req_addr_q;
    assign req_tag_o   = req_tag_q;

endmodule

// File: rtl/mem_writeback_stage.sv
// *************************************************************************
// Memory writeback stage
// Retires the finished head load, merges its one or two lines with a
// byte shifter and drives the registered register write port
// *************************************************************************

`include "lsu_config.svh"

module mem_writeback_stage (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       flush_i,
    input  logic                       head_ready_i,      // Head load finished
    input  lsu_instr_pkg::load_instr_t head_instr_i,
    input  lsu_mem_pkg::line_data_t    head_line_lo_i,
    input  lsu_mem_pkg::line_data_t    head_line_hi_i,
    output logic                       pop_o,             // Advance queue head
    output logic                       wb_valid_o,
    output logic [`LSU_DEST_W-1:0]     wb_dest_o,
    output lsu_instr_pkg::wb_data_t    wb_data_o
);

    lsu_instr_pkg::byte_off_t     head_off;
    logic [2*`LSU_LINE_BYTES*8-1:0] line_pair;   // Upper line above lower
    lsu_instr_pkg::wb_data_t      shift_data;

    logic                         wb_valid_q;
    logic [`LSU_DEST_W-1:0]       wb_dest_q;
    lsu_instr_pkg::wb_data_t      wb_data_q;

    // Flush wins over a retire in the same cycle
    assign pop_o = head_ready_i & ~flush_i;

    assign head_off = lsu_instr_pkg::byte_off_t'(head_instr_i.addr);

    // Result byte i is byte i+k of the lower line, past the end it wraps
    // into the upper line at i+k-8
    always_comb begin
        line_pair = {head_line_hi_i, head_line_lo_i};
        for (int i = 0; i < `LSU_LINE_BYTES; i++) begin
            shift_data[i*8 +: 8] = line_pair[(i + head_off)*8 +: 8];
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= pop_o;                  // One retire per cycle
        end
    end

    // Write port payload
    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            wb_dest_q <= head_instr_i.dest;
            wb_data_q <= shift_data;
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_dest_o  = wb_dest_q;
    assign wb_data_o  = wb_data_q;

endmodule

// File: rtl/pending_mem_req_queue.sv
// *************************************************************************
// Pending memory request queue
// Circular table that keeps loads in program order and collects their
// line responses by tag, one line for aligned loads, two for unaligned
// *************************************************************************

`include "lsu_config.svh"

module pending_mem_req_queue (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       flush_i,            // Empty the queue
    input  logic                       alloc_valid_i,
    input  lsu_instr_pkg::load_instr_t alloc_instr_i,
    input  lsu_mem_pkg::mem_tag_t      alloc_tag_i,
    input  logic                       alloc_unaligned_i,
    input  logic                       rsp_valid_i,
    input  lsu_mem_pkg::mem_tag_t      rsp_tag_i,
    input  lsu_mem_pkg::line_data_t    rsp_data_i,
    input  logic                       pop_i,              // Retire head
    output logic                       head_ready_o,
    output lsu_instr_pkg::load_instr_t head_instr_o,
    output lsu_mem_pkg::line_data_t    head_line_lo_o,
    output lsu_mem_pkg::line_data_t    head_line_hi_o,
    output logic                       full_o
);

    localparam int DEPTH = `LSU_PMRQ_ENTRIES;
    localparam int PTR_W = $clog2(DEPTH);

    logic [PTR_W-1:0] head_q;           // Oldest load
    logic [PTR_W-1:0] tail_q;           // Next free slot
    logic [PTR_W:0]   count_q;          // One bit wider than the pointers

    logic             write_en;
    logic             pop_en;

    // Per entry status
    logic [DEPTH-1:0] unal_q;
    logic [DEPTH-1:0] lo_done_q;        // Line at tag received
    logic [DEPTH-1:0] hi_done_q;        // Line at tag+1 received

    // Per entry payload
    lsu_instr_pkg::load_instr_t instr_tbl [0:DEPTH-1];
    lsu_mem_pkg::mem_tag_t      tag_tbl   [0:DEPTH-1];
    lsu_mem_pkg::line_data_t    lo_tbl    [0:DEPTH-1];
    lsu_mem_pkg::line_data_t    hi_tbl    [0:DEPTH-1];

    // Response match per entry
    logic [DEPTH-1:0] lo_hit;
    logic [DEPTH-1:0] hi_hit;

    assign write_en = alloc_valid_i & (count_q < DEPTH);
    assign pop_en   = pop_i & (count_q != '0);

    // Every entry watches the response bus
    always_comb begin
        for (int j = 0; j < DEPTH; j++) begin
            lo_hit[j] = rsp_valid_i & (tag_tbl[j] == rsp_tag_i);
            // Upper half of an unaligned load carries the next tag
            hi_hit[j] = rsp_valid_i & unal_q[j] &
                        (lsu_mem_pkg::mem_tag_t'(tag_tbl[j] + 1'b1) == rsp_tag_i);
        end
    end

    // Pointers and count
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (write_en) begin
                tail_q <= tail_q + 1'b1;
            end
            if (pop_en) begin
                head_q <= head_q + 1'b1;
            end
            count_q <= count_q + write_en - pop_en;
        end
    end

    // Status bits, a new allocation overrides a stale hit on its slot
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            unal_q    <= '0;
            lo_done_q <= '0;
            hi_done_q <= '0;
        end else begin
            for (int j = 0; j < DEPTH; j++) begin
                if (lo_hit[j]) begin
                    lo_done_q[j] <= 1'b1;
                end
                if (hi_hit[j]) begin
                    hi_done_q[j] <= 1'b1;
                end
            end
            if (write_en) begin
                unal_q[tail_q]    <= alloc_unaligned_i;
                lo_done_q[tail_q] <= 1'b0;
                hi_done_q[tail_q] <= 1'b0;
            end
        end
    end

    // Instruction, tag and line storage
    always_ff @(posedge clk_i) begin
        for (int j = 0; j < DEPTH; j++) begin
            if (lo_hit[j]) begin
                lo_tbl[j] <= rsp_data_i;
            end
            if (hi_hit[j]) begin
                hi_tbl[j] <= rsp_data_i;
            end
        end
        if (write_en) begin
            instr_tbl[tail_q] <= alloc_instr_i;
            tag_tbl[tail_q]   <= alloc_tag_i;
        end
    end

    // Head done once every line it needs has arrived
    assign head_ready_o = (count_q != '0) & lo_done_q[head_q] &
                          (~unal_q[head_q] | hi_done_q[head_q]);

    assign head_instr_o   = instr_tbl[head_q];
    assign head_line_lo_o = lo_tbl[head_q];
    assign head_line_hi_o = hi_tbl[head_q];  // Meaningful for unaligned only

    // Two slots of slack for an allocation already in flight
    assign full_o = (count_q >= DEPTH - 2);

endmodule

// File: sources.f
+incdir+rtl
+incdir+dv
rtl/lsu_instr_pkg.sv
rtl/lsu_mem_pkg.sv
rtl/mem_req_issue.sv
rtl/pending_mem_req_queue.sv
rtl/mem_writeback_stage.sv
rtl/lsu_mem_top.sv
dv/lsu_mem_tb.sv
